/* tcb_settings.svh */
// bus and memory dimensions shared by package and RTL
// byte lanes assumed 8 bits wide, so data width must be 8 x byte count

`ifndef TCB_SETTINGS_SVH
`define TCB_SETTINGS_SVH

//////////////////////////////
// bus widths
//////////////////////////////

// word address width
`define TCB_ADR_WIDTH 10

// data width in bits
`define TCB_DAT_WIDTH 32

// number of byte lanes
`define TCB_BYT_WIDTH 4

//////////////////////////////
// memory
//////////////////////////////

// words held by the memory, addresses at or above are out of range
`define TCB_MEM_DEPTH 256

`endif

/* tcb_pkg.sv */
// request and response types for the tightly coupled bus
// widths come from the settings header

package tcb_pkg;

  `include "tcb_settings.svh"

  //////////////////////////////
  // request
  //////////////////////////////

  // one request per handshake transfer
  typedef struct packed {
    // write enable, low for read
    logic                      wen;
    // word address
    logic [`TCB_ADR_WIDTH-1:0] adr;
    // byte enables, one per lane
    logic [`TCB_BYT_WIDTH-1:0] byt;
    // write data, ignored on read
    logic [`TCB_DAT_WIDTH-1:0] wdt;
  } tcb_req_t;

  //////////////////////////////
  // response
  //////////////////////////////

  // one response per accepted request, in order
  typedef struct packed {
    // read data, zero on write or error
    logic [`TCB_DAT_WIDTH-1:0] rdt;
    // address out of range
    logic                      err;
  } tcb_rsp_t;

endpackage

/* tcb_register_backpressure.sv */
// skid-buffer slice, up_rdy comes from a register, one stalled request held
// request path is combinational while up_rdy is high

`timescale 1ns/10ps

module tcb_register_backpressure #(
  parameter type payload_t = tcb_pkg::tcb_req_t
) (
  input  logic     sub,
  input  logic     arst_n,
  // upstream, manager side
  input  logic     up_vld,
  output logic     up_rdy,
  input  payload_t up_req,
  // downstream, subordinate side
  output logic     dn_vld,
  input  logic     dn_rdy,
  output payload_t dn_req
);

  //////////////////////////////
  // skid buffer
  //////////////////////////////

  // holds the request caught by a stall
  payload_t tmp;

  // capture when upstream transfer meets a stall
  always_ff @(posedge sub) begin
    if (up_vld & up_rdy & ~dn_rdy) begin
      tmp <= up_req;
    end
  end

  // pass through while ready
  // buffered copy forced valid otherwise
  assign dn_vld = up_rdy ? up_vld : 1'b1;
  assign dn_req = up_rdy ? up_req : tmp;

  //////////////////////////////
  // ready register
  //////////////////////////////

  // drops after a stalled transfer
  // once low, follows downstream ready
  always_ff @(posedge sub or negedge arst_n) begin
    if (!arst_n) begin
      up_rdy <= 1'b1;
    end else if (up_rdy) begin
      up_rdy <= ~(up_vld & ~dn_rdy);
    end else begin
      up_rdy <= dn_rdy;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // refused request kept steady by the manager until taken
  a_up_stable: assert property (
    @(posedge sub) disable iff (!arst_n)
    (up_vld && !up_rdy) |=> (up_vld && $stable(up_req))
  );

  // stalled request held across the pass-through to buffer switch
  a_dn_stable: assert property (
    @(posedge sub) disable iff (!arst_n)
    (dn_vld && !dn_rdy) |=> (dn_vld && $stable(dn_req))
  );

endmodule

/* tcb_register_forward.sv */
// one-stage register on valid and request toward the subordinate
// up_rdy is combinational from fill state and dn_rdy

`timescale 1ns/10ps

module tcb_register_forward #(
  parameter type payload_t = tcb_pkg::tcb_req_t
) (
  input  logic     sub,
  input  logic     arst_n,
  // upstream, manager side
  input  logic     up_vld,
  output logic     up_rdy,
  input  payload_t up_req,
  // downstream, subordinate side
  output logic     dn_vld,
  input  logic     dn_rdy,
  output payload_t dn_req
);

  //////////////////////////////
  // pipeline register
  //////////////////////////////

  // fill state
  logic     vld_q;
  // registered request, no reset
  payload_t req_q;

  // empty or emptying this cycle
  assign up_rdy = ~vld_q | dn_rdy;

  // valid loads whenever the stage can move
  always_ff @(posedge sub or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= 1'b0;
    end else if (up_rdy) begin
      vld_q <= up_vld;
    end
  end

  // payload only on a real transfer
  always_ff @(posedge sub) begin
    if (up_vld & up_rdy) begin
      req_q <= up_req;
    end
  end

  assign dn_vld = vld_q;
  assign dn_req = req_q;

  //////////////////////////////
  // checks
  //////////////////////////////

  // stalled content kept until taken
  a_dn_stable: assert property (
    @(posedge sub) disable iff (!arst_n)
    (dn_vld && !dn_rdy) |=> (dn_vld && $stable(dn_req))
  );

endmodule

/* tcb_memory.sv */
// word-addressed memory, byte-enabled writes, one-cycle stall after each write
// contents undefined after power-up, reset leaves the array alone

`timescale 1ns/10ps

`include "tcb_settings.svh"

module tcb_memory (
  input  logic              sub,
  input  logic              arst_n,
  // request handshake
  input  logic              vld,
  output logic              rdy,
  input  tcb_pkg::tcb_req_t req,
  // response, not stallable
  output logic              rsp_vld,
  output tcb_pkg::tcb_rsp_t rsp
);

  import tcb_pkg::*;

  // array index width
  localparam int unsigned IDX_WIDTH = $clog2(`TCB_MEM_DEPTH);

  //////////////////////////////
  // decode
  //////////////////////////////

  // accepted request
  logic                 trn;
  // address inside the array
  logic                 in_range;
  // truncated word index
  logic [IDX_WIDTH-1:0] idx;

  assign trn      = vld & rdy;
  assign in_range = (req.adr < `TCB_MEM_DEPTH);
  assign idx      = req.adr[IDX_WIDTH-1:0];

  //////////////////////////////
  // write recovery
  //////////////////////////////

  // high for the cycle after an accepted write
  logic busy;

  always_ff @(posedge sub or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
    end else begin
      busy <= trn & req.wen;
    end
  end

  // ready from the busy register only
  assign rdy = ~busy;

  //////////////////////////////
  // storage
  //////////////////////////////

  logic [`TCB_DAT_WIDTH-1:0] mem [0:`TCB_MEM_DEPTH-1];

  // only enabled lanes, out-of-range writes dropped
  always_ff @(posedge sub) begin
    if (trn & req.wen & in_range) begin
      for (int unsigned i = 0; i < `TCB_BYT_WIDTH; i++) begin
        if (req.byt[i]) begin
          mem[idx][8*i +: 8] <= req.wdt[8*i +: 8];
        end
      end
    end
  end

  //////////////////////////////
  // response
  //////////////////////////////

  // next response payload
  tcb_rsp_t rsp_d;

  // read data only for in-range reads
  always_comb begin
    rsp_d.err = ~in_range;
    rsp_d.rdt = '0;
    if (~req.wen & in_range) begin
      rsp_d.rdt = mem[idx];
    end
  end

  // pulse one cycle after each transfer
  always_ff @(posedge sub or negedge arst_n) begin
    if (!arst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= trn;
    end
  end

  // payload register, no reset
  always_ff @(posedge sub) begin
    if (trn) begin
      rsp <= rsp_d;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // request refused in the recovery cycle stays on the bus until taken
  a_recovery_hold: assert property (
    @(posedge sub) disable iff (!arst_n)
    (vld && !rdy) |=> (vld && $stable(req))
  );

endmodule

/* tcb_register_chain.sv */
// backpressure slice, forward slice and memory in a chain
// response latency varies, rsp_vld marks each response

`timescale 1ns/10ps

module tcb_register_chain (
  input  logic              sub,
  input  logic              arst_n,
  // manager request
  input  logic              up_vld,
  output logic              up_rdy,
  input  tcb_pkg::tcb_req_t up_req,
  // response, in request order
  output logic              rsp_vld,
  output tcb_pkg::tcb_rsp_t rsp
);

  import tcb_pkg::*;

  //////////////////////////////
  // links
  //////////////////////////////

  // backpressure slice to forward slice
  logic     bp_vld;
  logic     bp_rdy;
  tcb_req_t bp_req;

  // forward slice to memory
  logic     fw_vld;
  logic     fw_rdy;
  tcb_req_t fw_req;

  //////////////////////////////
  // chain
  //////////////////////////////

  // cuts the ready path
  tcb_register_backpressure #(
    .payload_t (tcb_req_t)
  ) u_backpressure (
    .sub    (sub),
    .arst_n (arst_n),
    .up_vld (up_vld),
    .up_rdy (up_rdy),
    .up_req (up_req),
    .dn_vld (bp_vld),
    .dn_rdy (bp_rdy),
    .dn_req (bp_req)
  );

  // cuts valid and request
  tcb_register_forward #(
    .payload_t (tcb_req_t)
  ) u_forward (
    .sub    (sub),
    .arst_n (arst_n),
    .up_vld (bp_vld),
    .up_rdy (bp_rdy),
    .up_req (bp_req),
    .dn_vld (fw_vld),
    .dn_rdy (fw_rdy),
    .dn_req (fw_req)
  );

  // response goes straight to the top
  tcb_memory u_memory (
    .sub     (sub),
    .arst_n  (arst_n),
    .vld     (fw_vld),
    .rdy     (fw_rdy),
    .req     (fw_req),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

endmodule

/* tcb_register_chain_tb.sv */
// reads tcb_register_chain_stimulus.txt from the working directory, one response per request
// idle gaps come from a fixed seed, so every run drives the same sequence

`timescale 1ns/10ps

`include "tcb_settings.svh"

module tcb_register_chain_tb;

  import tcb_pkg::*;

  // room for stimulus lines
  localparam int MAX_LINES = 256;

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic     sub = 1'b0;
  logic     arst_n;
  logic     up_vld;
  logic     up_rdy;
  tcb_req_t up_req;
  logic     rsp_vld;
  tcb_rsp_t rsp;

  //////////////////////////////
  // stimulus and scoreboard
  //////////////////////////////

  // one entry per data line of the file
  tcb_req_t st_req  [MAX_LINES];
  tcb_rsp_t st_rsp  [MAX_LINES];
  int       st_test [MAX_LINES];
  int       n_lines = 0;

  // expected responses, oldest first
  tcb_rsp_t exp_q [$];

  int     req_cnt   = 0;
  int     rsp_cnt   = 0;
  int     fail_cnt  = 0;
  int     tests_ok  = 0;
  int     tests_bad = 0;
  integer seed;
  logic   loaded    = 1'b0;

  tcb_register_chain dut (
    .sub     (sub),
    .arst_n  (arst_n),
    .up_vld  (up_vld),
    .up_rdy  (up_rdy),
    .up_req  (up_req),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  // 10 ns clock
  always #5 sub = ~sub;

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic string test_name(input int id);
    case (id)
      1: return "reset state";
      2: return "full-word writes and reads";
      3: return "byte enables";
      4: return "backpressure integrity";
      5: return "range error";
      6: return "drain";
      default: return "unnamed";
    endcase
  endfunction

  // mostly 0, sometimes 1 or 2 idle cycles
  function automatic int pick_gap();
    int r;
    r = $unsigned($random(seed)) % 8;
    return (r < 5) ? 0 : ((r < 7) ? 1 : 2);
  endfunction

  // data lines hold six hex fields, "test n" starts behavior n
  task automatic load_stimulus(output bit ok);
    int       fd;
    int       cur;
    int       num;
    string    line;
    logic                      f_wen;
    logic [`TCB_ADR_WIDTH-1:0] f_adr;
    logic [`TCB_BYT_WIDTH-1:0] f_byt;
    logic [`TCB_DAT_WIDTH-1:0] f_wdt;
    logic [`TCB_DAT_WIDTH-1:0] f_rdt;
    logic                      f_err;
    ok  = 1'b0;
    cur = 0;
    fd  = $fopen("tcb_register_chain_stimulus.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%h %h %h %h %h %h", f_wen, f_adr, f_byt, f_wdt, f_rdt, f_err) == 6)
        begin
          if (n_lines < MAX_LINES) begin
            st_req[n_lines].wen = f_wen;
            st_req[n_lines].adr = f_adr;
            st_req[n_lines].byt = f_byt;
            st_req[n_lines].wdt = f_wdt;
            st_rsp[n_lines].rdt = f_rdt;
            st_rsp[n_lines].err = f_err;
            st_test[n_lines]    = cur;
            n_lines++;
          end
        end else if ($sscanf(line, "test %d", num) == 1) begin
          cur = num;
        end
      end
      $fclose(fd);
      ok = (n_lines > 0);
    end
  endtask

  task automatic report_test(input int id, input int fail0, input int nreq);
    if (fail_cnt == fail0) begin
      tests_ok++;
      $display("test %0d %s: ok, %0d requests", id, test_name(id), nreq);
    end else begin
      tests_bad++;
      $display("test %0d %s: FAILED, %0d errors", id, test_name(id), fail_cnt - fail0);
    end
  endtask

  // held until up_rdy is seen high at an edge
  task automatic send_request(input int k);
    up_vld <= 1'b1;
    up_req <= st_req[k];
    @(posedge sub);
    while (up_rdy !== 1'b1) begin
      @(posedge sub);
    end
    exp_q.push_back(st_rsp[k]);
    req_cnt++;
  endtask

  //////////////////////////////
  // test steps
  //////////////////////////////

  task automatic check_reset();
    int fail0;
    fail0 = fail_cnt;
    repeat (5) @(posedge sub);
    arst_n <= 1'b1;
    @(posedge sub);
    assert (up_rdy === 1'b1) else begin
      $display("[ERROR] %0t up_rdy expected 1 actual %b", $time, up_rdy);
      fail_cnt++;
    end
    assert (rsp_vld === 1'b0) else begin
      $display("[ERROR] %0t rsp_vld expected 0 actual %b", $time, rsp_vld);
      fail_cnt++;
    end
    report_test(1, fail0, 0);
  endtask

  // wait for outstanding responses, then a few quiet cycles for strays
  task automatic close_test(input int id, input int req0, input int rsp0, input int fail0);
    up_vld <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge sub);
    end
    repeat (3) @(posedge sub);
    if (id == 4) begin
      assert ((rsp_cnt - rsp0) == (req_cnt - req0)) else begin
        $display("backpressure test got %0d responses for %0d requests",
                 rsp_cnt - rsp0, req_cnt - req0);
        fail_cnt++;
      end
    end
    if (id == 6) begin
      assert (exp_q.size() == 0 && rsp_cnt == req_cnt) else begin
        $display("drain left %0d responses outstanding, %0d responses for %0d requests",
                 exp_q.size(), rsp_cnt, req_cnt);
        fail_cnt++;
      end
    end
    report_test(id, fail0, req_cnt - req0);
  endtask

  // segments of the file run one after another
  task automatic run_requests();
    int k;
    int cur;
    int gap;
    int req0;
    int rsp0;
    int fail0;
    cur   = 0;
    req0  = 0;
    rsp0  = 0;
    fail0 = 0;
    for (k = 0; k < n_lines; k++) begin
      if (st_test[k] != cur) begin
        if (cur != 0) begin
          close_test(cur, req0, rsp0, fail0);
        end
        cur   = st_test[k];
        req0  = req_cnt;
        rsp0  = rsp_cnt;
        fail0 = fail_cnt;
      end
      send_request(k);
      gap = pick_gap();
      if (gap > 0) begin
        up_vld <= 1'b0;
        repeat (gap) @(posedge sub);
      end
    end
    close_test(cur, req0, rsp0, fail0);
  endtask

  //////////////////////////////
  // response checker
  //////////////////////////////

  task automatic check_response();
    tcb_rsp_t e;
    rsp_cnt++;
    assert (exp_q.size() != 0) else begin
      $display("response %0d arrived at %0t with no request outstanding", rsp_cnt, $time);
      fail_cnt++;
    end
    if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      assert (rsp.err === e.err) else begin
        $display("[ERROR] %0t rsp.err expected %b actual %b", $time, e.err, rsp.err);
        fail_cnt++;
      end
      assert (rsp.rdt === e.rdt) else begin
        $display("[ERROR] %0t rsp.rdt expected %h actual %h", $time, e.rdt, rsp.rdt);
        fail_cnt++;
      end
    end
  endtask

  // outputs are registered, stable at the edge
  always @(posedge sub) begin
    if (arst_n === 1'b1 && rsp_vld === 1'b1) begin
      check_response();
    end
  end

  //////////////////////////////
  // main and watchdog
  //////////////////////////////

  initial begin
    bit ok;
    seed   = 30051;
    arst_n = 1'b0;
    up_vld = 1'b0;
    up_req = '0;
    load_stimulus(ok);
    if (!ok) begin
      $display("could not read any request from the stimulus file");
      $display("Testbench failed");
      $finish;
    end else begin
      loaded = 1'b1;
      check_reset();
      run_requests();
      $display("summary: %0d tests passed, %0d tests failed, %0d checks failed",
               tests_ok, tests_bad, fail_cnt);
      if (fail_cnt == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

  // limit scales with the number of requests
  initial begin
    int limit;
    wait (loaded === 1'b1);
    limit = n_lines * 6 + 50;
    repeat (limit) @(posedge sub);
    $display("timeout: run did not finish within %0d clock cycles, %0d responses outstanding",
             limit, exp_q.size());
    $display("Testbench failed");
    $finish;
  end

endmodule

/* tcb_register_chain_stimulus.txt */
// columns in hex: wen adr byt wdt expected_rdt expected_err
// a line "test n" starts behavior n, lines starting with // are skipped
test 2
1 000 f 12345678 00000000 0
1 001 f deadbeef 00000000 0
1 0ff f 0badf00d 00000000 0
0 000 0 00000000 12345678 0
0 001 0 00000000 deadbeef 0
0 0ff 0 00000000 0badf00d 0
test 3
1 010 f 11223344 00000000 0
1 010 1 aaaaaaaa 00000000 0
0 010 0 00000000 112233aa 0
1 010 6 bbccddee 00000000 0
1 010 8 99000000 00000000 0
0 010 0 00000000 99ccddaa 0
1 011 f 00000000 00000000 0
1 011 5 ffffffff 00000000 0
1 011 0 12345678 00000000 0
0 011 0 00000000 00ff00ff 0
test 4
1 020 f 00000020 00000000 0
1 021 f 11110021 00000000 0
1 022 f 22220022 00000000 0
1 023 f 33330023 00000000 0
0 020 0 00000000 00000020 0
0 023 0 00000000 33330023 0
1 024 f 44440024 00000000 0
0 024 0 00000000 44440024 0
0 021 0 00000000 11110021 0
0 022 0 00000000 22220022 0
test 5
1 100 f cafef00d 00000000 1
0 100 0 00000000 00000000 1
1 3ff f 11111111 00000000 1
0 3ff 0 00000000 00000000 1
1 110 3 22222222 00000000 1
0 000 0 00000000 12345678 0
0 0ff 0 00000000 0badf00d 0
0 010 0 00000000 99ccddaa 0
test 6
0 001 0 00000000 deadbeef 0
0 011 0 00000000 00ff00ff 0
0 022 0 00000000 22220022 0
0 024 0 00000000 44440024 0

/* tcb_register_chain.f */
+incdir+.
tcb_pkg.sv
tcb_register_backpressure.sv
tcb_register_forward.sv
tcb_memory.sv
tcb_register_chain.sv
tcb_register_chain_tb.sv

/* Makefile */
# Verilator flow for the TCB register chain

SIM        := verilator
TOP        := tcb_register_chain_tb
RTL_TOP    := tcb_register_chain
FILELIST   := tcb_register_chain.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
PASS_MSG   := Testbench passed

.PHONY: all lint sim clean

all: sim

# lint the RTL top level
lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# build and run, status from a search of the output
sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
